// File: Makefile
TOP = tb_mem_subsys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

// File: source/dcache.sv
`timescale 1ns/10ps
`default_nettype none

module dcache (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            rd_i,
    input  logic            wr_i,
    input  mem_pkg::addr_t  addr_i,
    input  mem_pkg::word_t  wdata_i,
    input  mem_pkg::strb_t  strb_i,
    output logic            valid_o,
    output mem_pkg::word_t  rdata_o,
    output logic            done_o,
    mem_bus_if.requester    mem
);

    mem_pkg::tag_t   tags  [mem_pkg::CACHE_LINES];
    mem_pkg::line_t  lines [mem_pkg::CACHE_LINES];
    logic [mem_pkg::CACHE_LINES-1:0] valid_bits;

    mem_pkg::cache_state_t state;
    mem_pkg::addr_t        addr_q;
    mem_pkg::word_t        wdata_q;
    mem_pkg::strb_t        strb_q;

    mem_pkg::index_t  idx;
    mem_pkg::offset_t off;
    mem_pkg::tag_t    tag;
    logic             hit;

    assign idx = addr_q[mem_pkg::LINE_LSB +: mem_pkg::INDEX_W];
    assign off = addr_q[mem_pkg::WORD_LSB +: mem_pkg::OFFSET_W];
    assign tag = addr_q[31:mem_pkg::TAG_LSB];
    assign hit = valid_bits[idx] && (tags[idx] == tag);

    // writes carry the word address, refills the aligned line
    assign mem.we    = (state == mem_pkg::WRITE);
    assign mem.addr  = mem.we ? addr_q
                              : {addr_q[31:mem_pkg::LINE_LSB], {mem_pkg::LINE_LSB{1'b0}}};
    assign mem.wdata = wdata_q;
    assign mem.wstrb = strb_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state      <= mem_pkg::IDLE;
            mem.req    <= 1'b0;
            valid_o    <= 1'b0;
            done_o     <= 1'b0;
            valid_bits <= '0;
        end else begin
            valid_o <= 1'b0;
            done_o  <= 1'b0;
            case (state)
                mem_pkg::IDLE: begin
                    if (rd_i) begin
                        state <= mem_pkg::LOOKUP;
                    end else if (wr_i) begin
                        mem.req <= 1'b1;   // write-through, straight to ram
                        state   <= mem_pkg::WRITE;
                    end
                end
                mem_pkg::LOOKUP: begin
                    if (hit) begin
                        valid_o <= 1'b1;
                        state   <= mem_pkg::IDLE;
                    end else begin
                        mem.req <= 1'b1;
                        state   <= mem_pkg::MISS;
                    end
                end
                mem_pkg::MISS: begin
                    if (mem.ack) begin
                        mem.req         <= 1'b0;
                        valid_o         <= 1'b1;
                        valid_bits[idx] <= 1'b1;
                        state           <= mem_pkg::IDLE;
                    end
                end
                mem_pkg::WRITE: begin
                    if (mem.ack) begin
                        mem.req <= 1'b0;
                        done_o  <= 1'b1;
                        state   <= mem_pkg::IDLE;
                    end
                end
                default: state <= mem_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_pkg::IDLE && (rd_i || wr_i)) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            strb_q  <= strb_i;
        end
        if (state == mem_pkg::LOOKUP) begin
            rdata_o <= mem_pkg::line_word(lines[idx], off);
        end
        if (state == mem_pkg::MISS && mem.ack) begin
            lines[idx] <= mem.rdata;
            tags[idx]  <= tag;
            rdata_o    <= mem_pkg::line_word(mem.rdata, off);
        end
        // no allocate on a write miss
        if (state == mem_pkg::WRITE && mem.ack && hit) begin
            lines[idx] <= mem_pkg::merge_word(lines[idx], off, wdata_q, strb_q);
        end
    end

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (rst_i) !(rd_i && wr_i)
    );

    a_req_when_idle: assert property (
        @(posedge clk) disable iff (rst_i) (rd_i || wr_i) |-> state == mem_pkg::IDLE
    );

endmodule

`default_nettype wire

// File: source/icache.sv
`timescale 1ns/10ps
`default_nettype none

module icache (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            req_i,
    input  mem_pkg::addr_t  addr_i,
    input  logic            flush_i,
    output logic            valid_o,
    output mem_pkg::word_t  inst_o,
    mem_bus_if.requester    mem
);

    mem_pkg::tag_t   tags  [mem_pkg::CACHE_LINES];
    mem_pkg::line_t  lines [mem_pkg::CACHE_LINES];
    logic [mem_pkg::CACHE_LINES-1:0] valid_bits;

    mem_pkg::cache_state_t state;
    mem_pkg::addr_t        addr_q;
    logic                  stale_q;   // flushed while refilling

    mem_pkg::index_t  idx;
    mem_pkg::offset_t off;
    mem_pkg::tag_t    tag;
    logic             hit;

    assign idx = addr_q[mem_pkg::LINE_LSB +: mem_pkg::INDEX_W];
    assign off = addr_q[mem_pkg::WORD_LSB +: mem_pkg::OFFSET_W];
    assign tag = addr_q[31:mem_pkg::TAG_LSB];
    assign hit = valid_bits[idx] && (tags[idx] == tag);

    // read-only port, always the aligned line
    assign mem.we    = 1'b0;
    assign mem.addr  = {addr_q[31:mem_pkg::LINE_LSB], {mem_pkg::LINE_LSB{1'b0}}};
    assign mem.wdata = '0;
    assign mem.wstrb = '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state      <= mem_pkg::IDLE;
            mem.req    <= 1'b0;
            valid_o    <= 1'b0;
            valid_bits <= '0;
            stale_q    <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (flush_i) begin
                valid_bits <= '0;
            end
            case (state)
                mem_pkg::IDLE: begin
                    if (req_i) begin
                        state <= mem_pkg::LOOKUP;
                    end
                end
                mem_pkg::LOOKUP: begin
                    if (hit) begin
                        valid_o <= 1'b1;
                        state   <= mem_pkg::IDLE;
                    end else begin
                        mem.req <= 1'b1;
                        stale_q <= 1'b0;
                        state   <= mem_pkg::MISS;
                    end
                end
                mem_pkg::MISS: begin
                    if (flush_i) begin
                        stale_q <= 1'b1;
                    end
                    if (mem.ack) begin
                        mem.req <= 1'b0;
                        valid_o <= 1'b1;
                        state   <= mem_pkg::IDLE;
                        if (!stale_q && !flush_i) begin
                            valid_bits[idx] <= 1'b1;   // data still returned if stale
                        end
                    end
                end
                default: state <= mem_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_pkg::IDLE && req_i) begin
            addr_q <= addr_i;
        end
        if (state == mem_pkg::LOOKUP) begin
            inst_o <= mem_pkg::line_word(lines[idx], off);
        end
        if (state == mem_pkg::MISS && mem.ack) begin
            lines[idx] <= mem.rdata;
            tags[idx]  <= tag;
            inst_o     <= mem_pkg::line_word(mem.rdata, off);
        end
    end

    // one fetch outstanding at a time
    a_req_when_idle: assert property (
        @(posedge clk) disable iff (rst_i) req_i |-> state == mem_pkg::IDLE
    );

endmodule

`default_nettype wire

// File: source/main_ram.sv
`timescale 1ns/10ps
`default_nettype none

module main_ram (
    input  logic      clk,
    input  logic      rst_i,
    mem_bus_if.memory bus
);

    mem_pkg::line_t mem [mem_pkg::RAM_LINES];

    logic                active;
    mem_pkg::lat_cnt_t   cnt;
    logic                fire;
    mem_pkg::ram_index_t line_idx;
    mem_pkg::offset_t    off;

    assign line_idx = bus.addr[mem_pkg::LINE_LSB +: mem_pkg::RAM_INDEX_W];
    assign off      = bus.addr[mem_pkg::WORD_LSB +: mem_pkg::OFFSET_W];
    // last wait cycle, ack goes out on this edge
    assign fire     = active && !bus.ack &&
                      (cnt == mem_pkg::lat_cnt_t'(mem_pkg::MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            active  <= 1'b0;
            cnt     <= '0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= fire;
            if (!active && bus.req) begin
                active <= 1'b1;
                cnt    <= mem_pkg::lat_cnt_t'(1);
            end else if (active && !bus.ack && !fire) begin
                cnt <= cnt + 1'b1;
            end else if (bus.ack) begin
                active <= 1'b0;   // req drops on this same edge
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            if (bus.we) begin
                mem[line_idx] <= mem_pkg::merge_word(mem[line_idx], off, bus.wdata, bus.wstrb);
            end else begin
                bus.rdata <= mem[line_idx];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  logic         clk,
    input  logic         rst_i,
    mem_bus_if.memory    ic,
    mem_bus_if.memory    dc,
    mem_bus_if.requester ram
);

    logic busy;     // grant held until ram ack
    logic owner;    // 0 icache, 1 dcache
    logic last;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            last  <= 1'b1;   // icache wins the first tie
        end else if (!busy) begin
            if (ic.req && dc.req) begin
                busy  <= 1'b1;
                owner <= ~last;
            end else if (ic.req || dc.req) begin
                busy  <= 1'b1;
                owner <= dc.req;
            end
        end else if (ram.ack) begin
            busy <= 1'b0;
            last <= owner;
        end
    end

    assign ram.req   = busy & (owner ? dc.req : ic.req);
    assign ram.we    = owner ? dc.we    : ic.we;
    assign ram.addr  = owner ? dc.addr  : ic.addr;
    assign ram.wdata = owner ? dc.wdata : ic.wdata;
    assign ram.wstrb = owner ? dc.wstrb : ic.wstrb;

    assign ic.ack   = busy & ~owner & ram.ack;
    assign dc.ack   = busy &  owner & ram.ack;
    assign ic.rdata = (busy && !owner) ? ram.rdata : '0;
    assign dc.rdata = (busy &&  owner) ? ram.rdata : '0;

    // ram only acks a live granted request
    a_ack_on_req: assert property (
        @(posedge clk) disable iff (rst_i) ram.ack |-> ram.req
    );

    // granted requester keeps its fields until the ack
    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst_i) ram.req && !ram.ack |=> $stable(ram.addr)
    );

endmodule

`default_nettype wire

// File: source/mem_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if;

    logic            req;
    logic            we;
    mem_pkg::addr_t  addr;
    mem_pkg::word_t  wdata;
    mem_pkg::strb_t  wstrb;
    mem_pkg::line_t  rdata;   // valid in the ack cycle
    logic            ack;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        output wstrb,
        input  rdata,
        input  ack
    );

    modport memory (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        input  wstrb,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int LINE_WORDS  = 8;
    localparam int CACHE_LINES = 16;
    localparam int RAM_LINES   = 256;   // 8 KiB, upper address bits ignored
    localparam int MEM_LATENCY = 3;

    localparam int WORD_LSB    = 2;
    localparam int OFFSET_W    = $clog2(LINE_WORDS);
    localparam int INDEX_W     = $clog2(CACHE_LINES);
    localparam int RAM_INDEX_W = $clog2(RAM_LINES);
    localparam int LINE_LSB    = WORD_LSB + OFFSET_W;   // index starts at bit 5
    localparam int TAG_LSB     = LINE_LSB + INDEX_W;

    typedef logic [31:0]                addr_t;
    typedef logic [31:0]                word_t;
    typedef logic [LINE_WORDS*32-1:0]   line_t;
    typedef logic [3:0]                 strb_t;
    typedef logic [31-TAG_LSB:0]        tag_t;
    typedef logic [INDEX_W-1:0]         index_t;
    typedef logic [OFFSET_W-1:0]        offset_t;
    typedef logic [RAM_INDEX_W-1:0]     ram_index_t;
    typedef logic [$clog2(MEM_LATENCY)-1:0] lat_cnt_t;

    typedef enum logic [1:0] {IDLE, LOOKUP, MISS, WRITE} cache_state_t;

    function automatic word_t line_word(line_t line, offset_t off);
        return line[int'(off) * 32 +: 32];
    endfunction

    // byte merge of one strobed word into a line
    function automatic line_t merge_word(line_t line, offset_t off, word_t data, strb_t strb);
        line_t merged;
        merged = line;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                merged[int'(off) * 32 + b * 8 +: 8] = data[b * 8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

// File: source/mem_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            if_req_i,
    input  mem_pkg::addr_t  if_addr_i,
    input  logic            if_flush_i,
    output logic            if_valid_o,
    output mem_pkg::word_t  if_inst_o,
    input  logic            d_rd_i,
    input  logic            d_wr_i,
    input  mem_pkg::addr_t  d_addr_i,
    input  mem_pkg::word_t  d_wdata_i,
    input  mem_pkg::strb_t  d_strb_i,
    output logic            d_valid_o,
    output mem_pkg::word_t  d_rdata_o,
    output logic            d_done_o
);

    mem_bus_if ic_bus();
    mem_bus_if dc_bus();
    mem_bus_if ram_bus();

    icache u_icache (
        .clk,
        .rst_i,
        .req_i(if_req_i),
        .addr_i(if_addr_i),
        .flush_i(if_flush_i),
        .valid_o(if_valid_o),
        .inst_o(if_inst_o),
        .mem(ic_bus.requester)
    );

    dcache u_dcache (
        .clk,
        .rst_i,
        .rd_i(d_rd_i),
        .wr_i(d_wr_i),
        .addr_i(d_addr_i),
        .wdata_i(d_wdata_i),
        .strb_i(d_strb_i),
        .valid_o(d_valid_o),
        .rdata_o(d_rdata_o),
        .done_o(d_done_o),
        .mem(dc_bus.requester)
    );

    mem_arbiter u_mem_arbiter (
        .clk,
        .rst_i,
        .ic(ic_bus.memory),
        .dc(dc_bus.memory),
        .ram(ram_bus.requester)
    );

    main_ram u_main_ram (
        .clk,
        .rst_i,
        .bus(ram_bus.memory)
    );

endmodule

`default_nettype wire

// File: testbench/mem_testdata.hex
// columns: opcode address wdata strobe expected_word, one record per line
// opcode 1 fetch, 2 load, 3 store, 4 flush, 5 fetch and load together
3 00000040 11112222 f 00000000
2 00000040 00000000 0 11112222
2 00000040 00000000 0 11112222
3 00000040 aabbccdd 3 00000000
2 00000040 00000000 0 1111ccdd
3 00000040 55667788 c 00000000
2 00000040 00000000 0 5566ccdd
3 00000044 01020304 f 00000000
2 00000044 00000000 0 01020304
1 00000044 00000000 0 01020304
1 00000044 00000000 0 01020304
3 00000040 deadbeef f 00000000
1 00000040 00000000 0 5566ccdd
4 00000000 00000000 0 00000000
1 00000040 00000000 0 deadbeef
3 00000200 cafef00d f 00000000
5 00000200 00000000 0 cafef00d
3 00000100 a5a5a5a5 f 00000000
3 00000300 5a5a5a5a f 00000000
2 00000100 00000000 0 a5a5a5a5
3 00000300 0f0f0f0f f 00000000
2 00000100 00000000 0 a5a5a5a5
2 00000300 00000000 0 0f0f0f0f

// File: testbench/tb_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys;

    localparam int MAX_RECS   = 64;
    localparam int REC_FIELDS = 5;    // op, addr, wdata, strb, expected
    localparam int OP_CYCLES  = 40;   // budget per record
    localparam int HIT_CYCLES = 2;    // request pulse to valid on a hit
    localparam int MODEL_WORDS = mem_pkg::RAM_LINES * mem_pkg::LINE_WORDS;

    localparam logic [31:0] OP_FETCH = 32'd1;
    localparam logic [31:0] OP_LOAD  = 32'd2;
    localparam logic [31:0] OP_STORE = 32'd3;
    localparam logic [31:0] OP_FLUSH = 32'd4;
    localparam logic [31:0] OP_BOTH  = 32'd5;

    logic           clk;
    logic           rst_i;
    logic           if_req_i;
    mem_pkg::addr_t if_addr_i;
    logic           if_flush_i;
    logic           if_valid_o;
    mem_pkg::word_t if_inst_o;
    logic           d_rd_i;
    logic           d_wr_i;
    mem_pkg::addr_t d_addr_i;
    mem_pkg::word_t d_wdata_i;
    mem_pkg::strb_t d_strb_i;
    logic           d_valid_o;
    mem_pkg::word_t d_rdata_o;
    logic           d_done_o;

    logic [31:0]    recs [MAX_RECS * REC_FIELDS];
    mem_pkg::word_t ram_model [MODEL_WORDS];
    mem_pkg::word_t ic_lines [mem_pkg::CACHE_LINES][mem_pkg::LINE_WORDS];
    mem_pkg::tag_t  ic_tags [mem_pkg::CACHE_LINES];
    logic [mem_pkg::CACHE_LINES-1:0] ic_valid;
    mem_pkg::tag_t  dc_tags [mem_pkg::CACHE_LINES];
    logic [mem_pkg::CACHE_LINES-1:0] dc_valid;

    logic           seen_if;
    logic           seen_d;
    logic           seen_done;
    mem_pkg::word_t inst_q;
    mem_pkg::word_t rdata_q;
    int             d_lat;
    int             n_recs;
    int             n_checks;
    int             n_errors;
    int             cycles;
    int             cycle_limit;

    mem_subsys_top DUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles, DUT stopped responding", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic mem_pkg::word_t apply_strobes(mem_pkg::word_t old, mem_pkg::word_t data,
                                                     mem_pkg::strb_t strb);
        mem_pkg::word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // icache shadow refilled from the ram model on a miss
    function automatic mem_pkg::word_t predict_fetch(mem_pkg::addr_t addr);
        int idx;
        int base;
        idx  = int'(addr[8:5]);
        base = int'(addr[12:5]) * mem_pkg::LINE_WORDS;
        if (!(ic_valid[idx] && ic_tags[idx] == addr[31:9])) begin
            for (int w = 0; w < mem_pkg::LINE_WORDS; w++) begin
                ic_lines[idx][w] = ram_model[base + w];
            end
            ic_tags[idx]  = addr[31:9];
            ic_valid[idx] = 1'b1;
        end
        return ic_lines[idx][int'(addr[4:2])];
    endfunction

    // dcache shadow, only loads allocate
    function automatic logic predict_load_hit(mem_pkg::addr_t addr);
        int   idx;
        logic hit;
        idx           = int'(addr[8:5]);
        hit           = dc_valid[idx] && dc_tags[idx] == addr[31:9];
        dc_tags[idx]  = addr[31:9];
        dc_valid[idx] = 1'b1;
        return hit;
    endfunction

    task automatic check_word(input string what, input mem_pkg::word_t got,
                              input mem_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_hit(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t %s: hit %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_done(input string what, input logic seen);
        n_checks++;
        if (seen !== 1'b1) begin
            n_errors++;
            $display("%0t %s: the data port never signalled write completion", $time, what);
        end
    endtask

    task automatic report_missing(input string what);
        n_errors++;
        $display("%0t %s: no valid pulse arrived within %0d cycles", $time, what, OP_CYCLES);
    endtask

    // sample on falling edges until every wanted pulse was seen
    task automatic wait_completion(input logic want_if, input logic want_d, input logic want_done);
        seen_if   = 1'b0;
        seen_d    = 1'b0;
        seen_done = 1'b0;
        for (int n = 0; n < OP_CYCLES; n++) begin
            @(negedge clk);
            if (if_valid_o) begin
                seen_if = 1'b1;
                inst_q  = if_inst_o;
            end
            if (d_valid_o) begin
                seen_d  = 1'b1;
                rdata_q = d_rdata_o;
                d_lat   = n + 2;   // two falling edges before the loop
            end
            if (d_done_o) begin
                seen_done = 1'b1;
            end
            if ((seen_if || !want_if) && (seen_d || !want_d) && (seen_done || !want_done)) begin
                break;
            end
        end
    endtask

    task automatic run_record(input int r);
        logic [31:0]    op;
        mem_pkg::addr_t addr;
        mem_pkg::word_t wdata;
        mem_pkg::strb_t strb;
        mem_pkg::word_t exp;
        logic           exp_hit;
        int             errs_before;
        op          = recs[r*REC_FIELDS];
        addr        = recs[r*REC_FIELDS + 1];
        wdata       = recs[r*REC_FIELDS + 2];
        strb        = recs[r*REC_FIELDS + 3][3:0];
        exp         = recs[r*REC_FIELDS + 4];
        errs_before = n_errors;
        @(negedge clk);
        case (op)
            OP_FETCH, OP_BOTH: begin
                if_req_i  = 1'b1;
                if_addr_i = addr;
                d_rd_i    = (op == OP_BOTH);
                d_addr_i  = addr;
                @(negedge clk);
                if_req_i = 1'b0;
                d_rd_i   = 1'b0;
                wait_completion(1'b1, op == OP_BOTH, 1'b0);
                check_word("icache model vs test data", predict_fetch(addr), exp);
                if (seen_if) check_word("fetch", inst_q, exp);
                else report_missing("fetch");
                if (op == OP_BOTH) begin
                    exp_hit = predict_load_hit(addr);
                    check_word("dcache model vs test data", ram_model[int'(addr[12:2])], exp);
                    if (seen_d) begin
                        check_word("load beside fetch", rdata_q, exp);
                        check_hit("load beside fetch", d_lat == HIT_CYCLES, exp_hit);
                    end else begin
                        report_missing("load beside fetch");
                    end
                end
            end
            OP_LOAD: begin
                d_rd_i   = 1'b1;
                d_addr_i = addr;
                @(negedge clk);
                d_rd_i = 1'b0;
                wait_completion(1'b0, 1'b1, 1'b0);
                exp_hit = predict_load_hit(addr);
                check_word("dcache model vs test data", ram_model[int'(addr[12:2])], exp);
                if (seen_d) begin
                    check_word("load", rdata_q, exp);
                    check_hit("load", d_lat == HIT_CYCLES, exp_hit);
                end else begin
                    report_missing("load");
                end
            end
            OP_STORE: begin
                d_wr_i    = 1'b1;
                d_addr_i  = addr;
                d_wdata_i = wdata;
                d_strb_i  = strb;
                @(negedge clk);
                d_wr_i = 1'b0;
                wait_completion(1'b0, 1'b0, 1'b1);
                check_done("store", seen_done);
                ram_model[int'(addr[12:2])] = apply_strobes(ram_model[int'(addr[12:2])],
                                                            wdata, strb);
            end
            OP_FLUSH: begin
                if_flush_i = 1'b1;
                @(negedge clk);
                if_flush_i = 1'b0;
                ic_valid   = '0;
            end
            default: begin
                n_errors++;
                $display("record %0d has an unknown opcode %h", r, op);
            end
        endcase
        $display("record %0d op %0h addr %h: %s", r, op, addr,
                 (n_errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        if_req_i    = 1'b0;
        if_addr_i   = '0;
        if_flush_i  = 1'b0;
        d_rd_i      = 1'b0;
        d_wr_i      = 1'b0;
        d_addr_i    = '0;
        d_wdata_i   = '0;
        d_strb_i    = '0;
        ic_valid    = '0;
        dc_valid    = '0;
        n_checks    = 0;
        n_errors    = 0;
        cycles      = 0;
        cycle_limit = 0;
        for (int i = 0; i < MAX_RECS * REC_FIELDS; i++) begin
            recs[i] = '0;
        end
        $readmemh("testbench/mem_testdata.hex", recs);
        n_recs = 0;
        while (n_recs < MAX_RECS && recs[n_recs*REC_FIELDS] != 32'h0) begin
            n_recs++;
        end
        if (n_recs == 0) begin
            n_errors++;
            $display("no records could be read from the data file");
        end
        cycle_limit = n_recs * OP_CYCLES;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        for (int r = 0; r < n_recs; r++) begin
            run_record(r);
        end
        $display("records %0d, checks %0d, errors %0d", n_recs, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/mem_pkg.sv
source/mem_bus_if.sv
source/icache.sv
source/dcache.sv
source/mem_arbiter.sv
source/main_ram.sv
source/mem_subsys_top.sv
testbench/tb_mem_subsys.sv
